// File: all.f
+incdir+.
dtlb_addr_pkg.sv
dtlb_port_pkg.sv
dtlb_sched.sv
dtlb_entry_array.sv
dtlb_mshr.sv
dtlb_top.sv
tb_dtlb_assert.sv
tb_dtlb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the data TLB testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_dtlb -o sim_dtlb

# Simulation output goes to a log, the verdict comes from that log
./obj_dir/sim_dtlb > sim.log 2>&1 || true
cat sim.log

if ! grep -qx "Test OK" sim.log; then
  exit 1
fi

// File: tb_dtlb.sv
/*
 * Data TLB testbench
 * Plays the LSQ and the level-2 TLB. A stimulus table walks the DUT
 * through misses, refills, permissions, page sizes, ASID flushes,
 * back-pressure and faulting walks
 */
module tb_dtlb
  import dtlb_addr_pkg::*;
  import dtlb_port_pkg::*;
();

  // Cycles any single wait may take
  localparam int TIMEOUT = 20;

  typedef enum logic [2:0] {
    ST_CSR,
    ST_REQ,
    ST_L2CHK,
    ST_ANS,
    ST_FLUSH,
    ST_RDY,
    ST_RDYCHK
  } kind_e;

  // One table row
  typedef struct packed {
    kind_e       kind;
    vpn_t        vpn;
    logic        store;
    logic [2:0]  p;       // Index into the random ppn table
    page_e       page;
    logic [5:0]  gurwxd;  // PTE bits g u r w x d
    logic        fault;   // Answer fault, or expected fault on a hit
    logic        want;    // Expected hit, wake-up or ready
    priv_e       priv;
    logic        sum;
    logic        mxr;
    asid_t       asid;
    flush_e      flush;
  } step_t;

  logic      clk_i;
  logic      rst_ni;
  logic      sum_i;
  logic      mxr_i;
  priv_e     priv_i;
  asid_t     asid_i;
  flush_e    flush_i;
  asid_t     flush_asid_i;
  lsq_req_t  lsq_req_i;
  logic      lsq_req_rdy_o;
  lsq_ans_t  lsq_ans_o;
  lsq_wup_t  lsq_wup_o;
  l2_req_t   l2_req_o;
  logic      l2_req_rdy_i;
  l2_ans_t   l2_ans_i;

  step_t  table_q [$];
  string  name_q [$];
  vpn_t   issued_q [$];
  ppn_t   ppn_tab [8];
  int     checks;
  int     mismatches;
  int     failures;

  dtlb_top dtlb_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .sum_i         (sum_i),
    .mxr_i         (mxr_i),
    .priv_i        (priv_i),
    .asid_i        (asid_i),
    .flush_i       (flush_i),
    .flush_asid_i  (flush_asid_i),
    .lsq_req_i     (lsq_req_i),
    .lsq_req_rdy_o (lsq_req_rdy_o),
    .lsq_ans_o     (lsq_ans_o),
    .lsq_wup_o     (lsq_wup_o),
    .l2_req_o      (l2_req_o),
    .l2_req_rdy_i  (l2_req_rdy_i),
    .l2_ans_i      (l2_ans_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Every level-2 request the DUT hands over
  always @(posedge clk_i) begin
    if (rst_ni && l2_req_o.valid && l2_req_rdy_i) begin
      issued_q.push_back(l2_req_o.vpn);
    end
  end

  function automatic vpn_t vpn_of(int a, int b, int c);
    return {vpn_lvl_t'(a), vpn_lvl_t'(b), vpn_lvl_t'(c)};
  endfunction

  function automatic void add(string nm, step_t s);
    table_q.push_back(s);
    name_q.push_back(nm);
  endfunction

  function automatic void set_csr(string nm, priv_e pv, logic su, logic mx, asid_t as);
    step_t s;
    s = '0;
    s.kind = ST_CSR;
    s.priv = pv;
    s.sum = su;
    s.mxr = mx;
    s.asid = as;
    add(nm, s);
  endfunction

  function automatic void lookup(string nm, vpn_t v, logic st, logic hit, logic flt,
                                 logic [2:0] p);
    step_t s;
    s = '0;
    s.kind = ST_REQ;
    s.vpn = v;
    s.store = st;
    s.want = hit;
    s.fault = flt;
    s.p = p;
    add(nm, s);
  endfunction

  function automatic void check_l2_req(string nm, vpn_t v);
    step_t s;
    s = '0;
    s.kind = ST_L2CHK;
    s.vpn = v;
    add(nm, s);
  endfunction

  function automatic void answer(string nm, vpn_t v, logic [2:0] p, page_e pg,
                                 logic [5:0] bits, logic flt);
    step_t s;
    s = '0;
    s.kind = ST_ANS;
    s.vpn = v;
    s.p = p;
    s.page = pg;
    s.gurwxd = bits;
    s.fault = flt;
    s.want = 1'b1;
    add(nm, s);
  endfunction

  function automatic void flush_tlb(string nm, flush_e fk, asid_t as);
    step_t s;
    s = '0;
    s.kind = ST_FLUSH;
    s.flush = fk;
    s.asid = as;
    add(nm, s);
  endfunction

  function automatic void set_l2_rdy(string nm, logic r);
    step_t s;
    s = '0;
    s.kind = ST_RDY;
    s.want = r;
    add(nm, s);
  endfunction

  function automatic void check_ready(string nm, logic r);
    step_t s;
    s = '0;
    s.kind = ST_RDYCHK;
    s.want = r;
    add(nm, s);
  endfunction

  // Miss, level-2 request, clean answer that fills an entry
  function automatic void refill(string nm, vpn_t v, logic [2:0] p, page_e pg,
                                 logic [5:0] bits);
    lookup({nm, "_miss"}, v, 1'b0, 1'b0, 1'b0, p);
    check_l2_req({nm, "_l2"}, v);
    answer({nm, "_ans"}, v, p, pg, bits, 1'b0);
  endfunction

  // Miss whose walk faults, so the slot frees and nothing is cached
  function automatic void probe_miss(string nm, vpn_t v);
    lookup({nm, "_miss"}, v, 1'b0, 1'b0, 1'b0, 3'd0);
    check_l2_req({nm, "_l2"}, v);
    answer({nm, "_ans"}, v, 3'd0, PAGE_KIBI, 6'b001101, 1'b1);
  endfunction

  function automatic void build_table();
    set_csr("init", PRIV_S, 1'b0, 1'b0, 16'd1);
    set_l2_rdy("rdy_on", 1'b1);
    // Miss, one level-2 request, duplicate dropped, refill, hit
    lookup("miss_a", vpn_of(1, 2, 3), 1'b0, 1'b0, 1'b0, 3'd0);
    check_l2_req("l2_a", vpn_of(1, 2, 3));
    lookup("miss_a_dup", vpn_of(1, 2, 3), 1'b0, 1'b0, 1'b0, 3'd0);
    answer("ans_a", vpn_of(1, 2, 3), 3'd0, PAGE_KIBI, 6'b001101, 1'b0);
    lookup("hit_a", vpn_of(1, 2, 3), 1'b0, 1'b1, 1'b0, 3'd0);
    lookup("hit_a_st", vpn_of(1, 2, 3), 1'b1, 1'b1, 1'b0, 3'd0);
    // Permissions
    refill("fill_clean", vpn_of(2, 0, 1), 3'd1, PAGE_KIBI, 6'b001100);
    lookup("st_clean", vpn_of(2, 0, 1), 1'b1, 1'b1, 1'b1, 3'd1);
    lookup("ld_clean", vpn_of(2, 0, 1), 1'b0, 1'b1, 1'b0, 3'd1);
    refill("fill_ro", vpn_of(2, 0, 2), 3'd2, PAGE_KIBI, 6'b001001);
    lookup("st_rdonly", vpn_of(2, 0, 2), 1'b1, 1'b1, 1'b1, 3'd2);
    lookup("ld_rdonly", vpn_of(2, 0, 2), 1'b0, 1'b1, 1'b0, 3'd2);
    refill("fill_user", vpn_of(2, 0, 3), 3'd3, PAGE_KIBI, 6'b011101);
    lookup("s_user_nosum", vpn_of(2, 0, 3), 1'b0, 1'b1, 1'b1, 3'd3);
    set_csr("sum_on", PRIV_S, 1'b1, 1'b0, 16'd1);
    lookup("s_user_sum", vpn_of(2, 0, 3), 1'b0, 1'b1, 1'b0, 3'd3);
    set_csr("u_mode", PRIV_U, 1'b0, 1'b0, 16'd1);
    lookup("u_super", vpn_of(1, 2, 3), 1'b0, 1'b1, 1'b1, 3'd0);
    lookup("u_user", vpn_of(2, 0, 3), 1'b0, 1'b1, 1'b0, 3'd3);
    set_csr("s_mode", PRIV_S, 1'b0, 1'b0, 16'd1);
    refill("fill_xonly", vpn_of(2, 0, 4), 3'd4, PAGE_KIBI, 6'b000010);
    lookup("x_nomxr", vpn_of(2, 0, 4), 1'b0, 1'b1, 1'b1, 3'd4);
    set_csr("mxr_on", PRIV_S, 1'b0, 1'b1, 16'd1);
    lookup("x_mxr", vpn_of(2, 0, 4), 1'b0, 1'b1, 1'b0, 3'd4);
    set_csr("mxr_off", PRIV_S, 1'b0, 1'b0, 16'd1);
    // Page sizes with a global gibi page
    refill("fill_mebi", vpn_of(5, 6, 7), 3'd5, PAGE_MEBI, 6'b001101);
    lookup("mebi_hit", vpn_of(5, 6, 100), 1'b0, 1'b1, 1'b0, 3'd5);
    refill("fill_gibi", vpn_of(9, 0, 0), 3'd6, PAGE_GIBI, 6'b101101);
    lookup("gibi_hit", vpn_of(9, 33, 44), 1'b0, 1'b1, 1'b0, 3'd6);
    probe_miss("kibi_miss", vpn_of(1, 2, 4));
    probe_miss("mebi_miss", vpn_of(5, 7, 7));
    // Faulting walk is not cached
    probe_miss("fault_walk", vpn_of(30, 1, 2));
    probe_miss("fault_again", vpn_of(30, 1, 2));
    // ASID switch and flushes
    set_csr("asid_2", PRIV_S, 1'b0, 1'b0, 16'd2);
    probe_miss("asid_miss", vpn_of(1, 2, 3));
    lookup("glob_hit", vpn_of(9, 1, 1), 1'b0, 1'b1, 1'b0, 3'd6);
    flush_tlb("flush_asid", FLUSH_ASID, 16'd1);
    set_csr("asid_1", PRIV_S, 1'b0, 1'b0, 16'd1);
    probe_miss("flushed_a", vpn_of(1, 2, 3));
    lookup("glob_kept", vpn_of(9, 2, 2), 1'b0, 1'b1, 1'b0, 3'd6);
    flush_tlb("flush_all", FLUSH_ALL, 16'd0);
    probe_miss("flushed_g", vpn_of(9, 2, 2));
    // Back-pressure fills the MSHR
    set_l2_rdy("rdy_off", 1'b0);
    lookup("bp_miss_1", vpn_of(20, 1, 1), 1'b0, 1'b0, 1'b0, 3'd1);
    lookup("bp_miss_2", vpn_of(21, 1, 1), 1'b0, 1'b0, 1'b0, 3'd2);
    check_ready("bp_full", 1'b0);
    set_l2_rdy("rdy_back", 1'b1);
    check_l2_req("bp_l2_1", vpn_of(20, 1, 1));
    check_l2_req("bp_l2_2", vpn_of(21, 1, 1));
    answer("bp_ans_1", vpn_of(20, 1, 1), 3'd1, PAGE_KIBI, 6'b001101, 1'b0);
    answer("bp_ans_2", vpn_of(21, 1, 1), 3'd2, PAGE_KIBI, 6'b001101, 1'b0);
    check_ready("bp_ready", 1'b1);
    lookup("bp_hit", vpn_of(20, 1, 1), 1'b0, 1'b1, 1'b0, 3'd1);
  endfunction

  task automatic compare(string nm, string what, logic [63:0] exp_v, logic [63:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      mismatches++;
      $display("mismatch %s %s expected %0h actual %0h", nm, what, exp_v, act_v);
    end
  endtask

  task automatic report(string msg);
    failures++;
    $display("%s", msg);
  endtask

  // Steps start and end 1 unit after a rising edge
  // Outputs are sampled at the falling edge
  task automatic run_step(string nm, step_t s);
    int n;
    n = 0;
    case (s.kind)
      ST_CSR: begin
        priv_i = s.priv;
        sum_i  = s.sum;
        mxr_i  = s.mxr;
        asid_i = s.asid;
        @(posedge clk_i);
        #1;
      end
      ST_REQ: begin
        lsq_req_i = '{valid: 1'b1, vpn: s.vpn, is_store: s.store, lsq_addr: {1'b0, s.p}};
        @(negedge clk_i);
        while (!lsq_req_rdy_o && n < TIMEOUT) begin
          @(negedge clk_i);
          n++;
        end
        if (!lsq_req_rdy_o) begin
          report($sformatf("step %s: LSQ request never accepted", nm));
        end else begin
          compare(nm, "ans valid", 64'(s.want), 64'(lsq_ans_o.valid));
          if (s.want) begin
            compare(nm, "ppn", 64'(ppn_tab[s.p]), 64'(lsq_ans_o.ppn));
            compare(nm, "page fault", 64'(s.fault), 64'(lsq_ans_o.page_fault));
            compare(nm, "was store", 64'(s.store), 64'(lsq_ans_o.was_store));
            compare(nm, "lsq addr", 64'({1'b0, s.p}), 64'(lsq_ans_o.lsq_addr));
          end
        end
        @(posedge clk_i);
        #1;
        lsq_req_i = '0;
      end
      ST_L2CHK: begin
        @(negedge clk_i);
        while (issued_q.size() == 0 && n < TIMEOUT) begin
          @(negedge clk_i);
          n++;
        end
        if (issued_q.size() == 0) begin
          report($sformatf("step %s: no level-2 request was issued", nm));
        end else begin
          compare(nm, "l2 vpn", 64'(s.vpn), 64'(issued_q.pop_front()));
        end
        @(posedge clk_i);
        #1;
      end
      ST_ANS: begin
        l2_ans_i = '{valid: 1'b1, vpn: s.vpn, ppn: ppn_tab[s.p], page_type: s.page,
                     g_bit: s.gurwxd[5], u_bit: s.gurwxd[4], r_bit: s.gurwxd[3],
                     w_bit: s.gurwxd[2], x_bit: s.gurwxd[1], d_bit: s.gurwxd[0],
                     page_fault: s.fault};
        @(negedge clk_i);
        compare(nm, "wup valid", 64'(s.want), 64'(lsq_wup_o.valid));
        compare(nm, "wup vpn", 64'(s.vpn), 64'(lsq_wup_o.vpn));
        compare(nm, "wup ppn", 64'(ppn_tab[s.p]), 64'(lsq_wup_o.ppn));
        compare(nm, "wup fault", 64'(s.fault), 64'(lsq_wup_o.page_fault));
        // Answer owns the array this cycle
        compare(nm, "lsq ready", 64'(0), 64'(lsq_req_rdy_o));
        @(posedge clk_i);
        #1;
        l2_ans_i = '0;
      end
      ST_FLUSH: begin
        flush_i      = s.flush;
        flush_asid_i = s.asid;
        @(posedge clk_i);
        #1;
        flush_i = FLUSH_NONE;
      end
      ST_RDY: begin
        l2_req_rdy_i = s.want;
        @(posedge clk_i);
        #1;
      end
      default: begin
        @(negedge clk_i);
        compare(nm, "lsq ready", 64'(s.want), 64'(lsq_req_rdy_o));
        @(posedge clk_i);
        #1;
      end
    endcase
  endtask

  initial begin
    void'($urandom(75));
    rst_ni       = 1'b0;
    sum_i        = 1'b0;
    mxr_i        = 1'b0;
    priv_i       = PRIV_S;
    asid_i       = '0;
    flush_i      = FLUSH_NONE;
    flush_asid_i = '0;
    lsq_req_i    = '0;
    l2_req_rdy_i = 1'b0;
    l2_ans_i     = '0;
    checks       = 0;
    mismatches   = 0;
    failures     = 0;
    for (int k = 0; k < 8; k++) begin
      ppn_tab[k] = {12'($urandom), $urandom};
    end
    build_table();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    foreach (table_q[i]) begin
      run_step(name_q[i], table_q[i]);
    end
    // Duplicates must not have produced extra walks
    if (issued_q.size() != 0) begin
      report($sformatf("%0d unexpected level-2 requests were issued", issued_q.size()));
    end
    $display("checks %0d mismatches %0d other failures %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tb_dtlb_assert.sv
/*
 * Data TLB protocol assertions
 * Bound into the top level: stalled level-2 requests hold still,
 * hit answers need an accepted request, outputs stay quiet in reset
 */
module tb_dtlb_assert
  import dtlb_addr_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  req_vld_i,
  input logic  req_rdy_i,
  input logic  ans_vld_i,
  input logic  wup_vld_i,
  input logic  l2_vld_i,
  input logic  l2_rdy_i,
  input vpn_t  l2_vpn_i
);

  // Stalled level-2 request keeps valid and page
  l2_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (l2_vld_i && !l2_rdy_i) |=> (l2_vld_i && $stable(l2_vpn_i)))
    else $error("level-2 request dropped or changed while stalled");

  // Hit answer only for a request taken this cycle
  ans_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ans_vld_i |-> (req_vld_i && req_rdy_i))
    else $error("LSQ answer without an accepted request");

  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> (!ans_vld_i && !wup_vld_i && !l2_vld_i))
    else $error("valid output raised during reset");

endmodule

bind dtlb_top tb_dtlb_assert tb_dtlb_assert_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_vld_i (lsq_req_i.valid),
  .req_rdy_i (lsq_req_rdy_o),
  .ans_vld_i (lsq_ans_o.valid),
  .wup_vld_i (lsq_wup_o.valid),
  .l2_vld_i  (l2_req_o.valid),
  .l2_rdy_i  (l2_req_rdy_i),
  .l2_vpn_i  (l2_req_o.vpn)
);

// File: dtlb_top.sv
/*
 * First-level data TLB
 * Scheduler, fully associative entry array and miss table.
 * Hits answer the LSQ in the same cycle, misses go to the level-2 TLB
 */
module dtlb_top
  import dtlb_addr_pkg::*;
  import dtlb_port_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // CSR state
  input  logic      sum_i,
  input  logic      mxr_i,
  input  priv_e     priv_i,
  input  asid_t     asid_i,
  // SFENCE.VMA
  input  flush_e    flush_i,
  input  asid_t     flush_asid_i,
  // LSQ side
  input  lsq_req_t  lsq_req_i,
  output logic      lsq_req_rdy_o,
  output lsq_ans_t  lsq_ans_o,
  output lsq_wup_t  lsq_wup_o,
  // Level-2 TLB side
  output l2_req_t   l2_req_o,
  input  logic      l2_req_rdy_i,
  input  l2_ans_t   l2_ans_i
);

  sched_e sched;
  logic   mshr_full;
  logic   tlb_hit;
  logic   ans_match;

  dtlb_sched dtlb_sched_i (
    .flush_i       (flush_i),
    .l2_ans_vld_i  (l2_ans_i.valid),
    .lsq_req_vld_i (lsq_req_i.valid),
    .mshr_full_i   (mshr_full),
    .sched_o       (sched),
    .lsq_req_rdy_o (lsq_req_rdy_o)
  );

  dtlb_entry_array dtlb_entry_array_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sched_i      (sched),
    .lsq_req_i    (lsq_req_i),
    .l2_ans_i     (l2_ans_i),
    .refill_ok_i  (ans_match),
    .flush_i      (flush_i),
    .flush_asid_i (flush_asid_i),
    .asid_i       (asid_i),
    .priv_i       (priv_i),
    .sum_i        (sum_i),
    .mxr_i        (mxr_i),
    .lsq_ans_o    (lsq_ans_o),
    .hit_o        (tlb_hit)
  );

  dtlb_mshr dtlb_mshr_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .sched_i      (sched),
    .req_vpn_i    (lsq_req_i.vpn),
    .tlb_hit_i    (tlb_hit),
    .l2_ans_i     (l2_ans_i),
    .l2_req_rdy_i (l2_req_rdy_i),
    .l2_req_o     (l2_req_o),
    .full_o       (mshr_full),
    .ans_match_o  (ans_match)
  );

  // Wake waiting LSQ slots only for answers the MSHR was tracking
  assign lsq_wup_o.valid      = ans_match;
  assign lsq_wup_o.vpn        = l2_ans_i.vpn;
  assign lsq_wup_o.ppn        = l2_ans_i.ppn;
  assign lsq_wup_o.page_fault = l2_ans_i.page_fault;

endmodule

// File: dtlb_mshr.sv
/*
 * Data TLB miss table
 * Allocates a slot per missing page, drops duplicates, offers pending
 * slots to the level-2 TLB and retires them when the answer returns
 */
`include "dtlb_consts.svh"

module dtlb_mshr
  import dtlb_addr_pkg::*;
  import dtlb_port_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  sched_e   sched_i,
  input  vpn_t     req_vpn_i,
  input  logic     tlb_hit_i,
  input  l2_ans_t  l2_ans_i,
  input  logic     l2_req_rdy_i,
  output l2_req_t  l2_req_o,
  output logic     full_o,
  output logic     ans_match_o
);

  logic [`DTLB_MSHR_DEPTH-1:0] valid_q;
  logic [`DTLB_MSHR_DEPTH-1:0] wait_q;
  vpn_t                        vpn_q [`DTLB_MSHR_DEPTH];
  logic [`DTLB_MSHR_DEPTH-1:0] dup_vec;
  logic [`DTLB_MSHR_DEPTH-1:0] match_vec;
  mshr_idx_t                   free_idx;
  mshr_idx_t                   pend_idx;
  mshr_idx_t                   issue_idx;
  mshr_idx_t                   hold_idx_q;
  logic                        hold_q;
  logic                        alloc;
  logic                        issue_fire;

  // Lowest free slot and lowest slot still to be sent
  always_comb begin
    free_idx = '0;
    pend_idx = '0;
    for (int k = `DTLB_MSHR_DEPTH - 1; k >= 0; k--) begin
      if (!valid_q[k]) begin
        free_idx = mshr_idx_t'(k);
      end
      if (valid_q[k] && !wait_q[k]) begin
        pend_idx = mshr_idx_t'(k);
      end
    end
  end

  // A stalled request keeps its slot until the level-2 TLB takes it
  assign issue_idx      = hold_q ? hold_idx_q : pend_idx;
  assign l2_req_o.valid = valid_q[issue_idx] && !wait_q[issue_idx];
  assign l2_req_o.vpn   = vpn_q[issue_idx];
  assign issue_fire     = l2_req_o.valid && l2_req_rdy_i;

  // Duplicate check on lookups, page-granular match on answers
  always_comb begin
    for (int k = 0; k < `DTLB_MSHR_DEPTH; k++) begin
      dup_vec[k] = valid_q[k] && (vpn_q[k] == req_vpn_i);
      case (l2_ans_i.page_type)
        PAGE_GIBI: match_vec[k] = (vpn_q[k][2] == l2_ans_i.vpn[2]);
        PAGE_MEBI: match_vec[k] = (vpn_q[k][2:1] == l2_ans_i.vpn[2:1]);
        default:   match_vec[k] = (vpn_q[k] == l2_ans_i.vpn);
      endcase
      match_vec[k] = match_vec[k] && valid_q[k] && (sched_i == SCHED_L2_ANS);
    end
  end

  assign alloc       = (sched_i == SCHED_LSQ_REQ) && !tlb_hit_i && !(|dup_vec);
  assign ans_match_o = |match_vec;
  assign full_o      = &valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      wait_q     <= '0;
      hold_q     <= 1'b0;
      hold_idx_q <= '0;
    end else begin
      hold_q     <= l2_req_o.valid && !l2_req_rdy_i;
      hold_idx_q <= issue_idx;
      for (int k = 0; k < `DTLB_MSHR_DEPTH; k++) begin
        if (match_vec[k]) begin
          // Retire beats a same-cycle issue
          valid_q[k] <= 1'b0;
          wait_q[k]  <= 1'b0;
        end else if (issue_fire && (issue_idx == mshr_idx_t'(k))) begin
          wait_q[k] <= 1'b1;
        end else if (alloc && (free_idx == mshr_idx_t'(k))) begin
          valid_q[k] <= 1'b1;
          wait_q[k]  <= 1'b0;
        end
      end
    end
  end

  // Missing page number
  always_ff @(posedge clk_i) begin
    if (alloc) begin
      vpn_q[free_idx] <= req_vpn_i;
    end
  end

endmodule

// File: dtlb_entry_array.sv
/*
 * Data TLB entry array
 * Fully associative storage with per-page-size lookup, ASID/global match
 * and Sv39 permission checks. Refills from the level-2 answer into the
 * first invalid entry or a round-robin victim, and flushes by ASID or all
 */
`include "dtlb_consts.svh"

module dtlb_entry_array
  import dtlb_addr_pkg::*;
  import dtlb_port_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  sched_e    sched_i,
  input  lsq_req_t  lsq_req_i,
  input  l2_ans_t   l2_ans_i,
  input  logic      refill_ok_i,
  input  flush_e    flush_i,
  input  asid_t     flush_asid_i,
  input  asid_t     asid_i,
  input  priv_e     priv_i,
  input  logic      sum_i,
  input  logic      mxr_i,
  output lsq_ans_t  lsq_ans_o,
  output logic      hit_o
);

  tlb_entry_t               entry_q [`DTLB_ENTRIES];
  logic [`DTLB_ENTRIES-1:0] hit_vec;
  logic [`DTLB_ENTRIES-1:0] flush_vec;
  tlb_idx_t                 hit_idx;
  tlb_idx_t                 victim_idx;
  tlb_idx_t                 rr_q;
  tlb_entry_t               hit_e;
  tlb_entry_t               new_entry;
  logic                     fault;
  logic                     refill_en;

  // Compare only the levels the page size translates
  function automatic logic page_match(tlb_entry_t e, vpn_t v);
    logic m;
    case (e.page_type)
      PAGE_GIBI: m = (e.vpn[2] == v[2]);
      PAGE_MEBI: m = (e.vpn[2:1] == v[2:1]);
      default:   m = (e.vpn == v);
    endcase
    return m;
  endfunction

  // Associative lookup picks the lowest matching entry
  always_comb begin
    hit_idx = '0;
    for (int k = `DTLB_ENTRIES - 1; k >= 0; k--) begin
      hit_vec[k] = entry_q[k].valid
                   && (entry_q[k].glob || (entry_q[k].asid == asid_i))
                   && page_match(entry_q[k], lsq_req_i.vpn);
      if (hit_vec[k]) begin
        hit_idx = tlb_idx_t'(k);
      end
    end
  end

  assign hit_o = |hit_vec;
  assign hit_e = entry_q[hit_idx];

  // First failing permission rule raises the fault
  always_comb begin
    fault = 1'b0;
    if (!hit_e.read && !mxr_i) begin
      // Execute-only page is readable only with MXR
      fault = 1'b1;
    end else if (lsq_req_i.is_store && !hit_e.write) begin
      fault = 1'b1;
    end else if (lsq_req_i.is_store && !hit_e.dirty) begin
      // Software must set D before a store to a clean page
      fault = 1'b1;
    end else if (hit_e.user && (priv_i == PRIV_S) && !sum_i) begin
      fault = 1'b1;
    end else if (!hit_e.user && (priv_i == PRIV_U)) begin
      fault = 1'b1;
    end
  end

  // Answer only when the lookup owns the array and hits
  always_comb begin
    lsq_ans_o.valid      = (sched_i == SCHED_LSQ_REQ) && hit_o;
    lsq_ans_o.ppn        = hit_e.ppn;
    lsq_ans_o.page_fault = fault;
    lsq_ans_o.was_store  = lsq_req_i.is_store;
    lsq_ans_o.lsq_addr   = lsq_req_i.lsq_addr;
  end

  // Entries selected by the flush kind
  always_comb begin
    for (int k = 0; k < `DTLB_ENTRIES; k++) begin
      case (flush_i)
        FLUSH_ASID: flush_vec[k] = entry_q[k].valid && !entry_q[k].glob
                                   && (entry_q[k].asid == flush_asid_i);
        FLUSH_ALL:  flush_vec[k] = 1'b1;
        default:    flush_vec[k] = 1'b0;
      endcase
    end
  end

  // Victim is the first invalid entry or else the round-robin pointer
  always_comb begin
    victim_idx = rr_q;
    for (int k = `DTLB_ENTRIES - 1; k >= 0; k--) begin
      if (!entry_q[k].valid) begin
        victim_idx = tlb_idx_t'(k);
      end
    end
  end

  // Faulting translations are never cached
  assign refill_en = (sched_i == SCHED_L2_ANS) && refill_ok_i && !l2_ans_i.page_fault;

  assign new_entry = '{
    valid:     1'b1,
    vpn:       l2_ans_i.vpn,
    ppn:       l2_ans_i.ppn,
    asid:      asid_i,
    glob:      l2_ans_i.g_bit,
    user:      l2_ans_i.u_bit,
    read:      l2_ans_i.r_bit,
    write:     l2_ans_i.w_bit,
    dirty:     l2_ans_i.d_bit,
    page_type: l2_ans_i.page_type
  };

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int k = 0; k < `DTLB_ENTRIES; k++) begin
        entry_q[k] <= '0;
      end
      rr_q <= '0;
    end else if (sched_i == SCHED_FLUSH) begin
      for (int k = 0; k < `DTLB_ENTRIES; k++) begin
        if (flush_vec[k]) begin
          entry_q[k].valid <= 1'b0;
        end
      end
    end else if (refill_en) begin
      entry_q[victim_idx] <= new_entry;
      // Pointer moves on every refill
      rr_q <= rr_q + 1'b1;
    end
  end

endmodule

// File: dtlb_sched.sv
/*
 * Data TLB scheduler
 * Fixed-priority arbiter for the entry array: flush, then level-2 refill,
 * then LSQ lookup. Also decides when the LSQ may present a request
 */
module dtlb_sched
  import dtlb_port_pkg::*;
(
  input  flush_e  flush_i,
  input  logic    l2_ans_vld_i,
  input  logic    lsq_req_vld_i,
  input  logic    mshr_full_i,
  output sched_e  sched_o,
  output logic    lsq_req_rdy_o
);

  // Highest priority source wins the array this cycle
  always_comb begin
    sched_o = SCHED_IDLE;
    if (flush_i != FLUSH_NONE) begin
      sched_o = SCHED_FLUSH;
    end else if (l2_ans_vld_i) begin
      // Level-2 answers have no ready, so they always beat the LSQ
      sched_o = SCHED_L2_ANS;
    end else if (lsq_req_vld_i && !mshr_full_i) begin
      sched_o = SCHED_LSQ_REQ;
    end
  end

  // No room for a possible miss when the MSHR is full
  assign lsq_req_rdy_o = (flush_i == FLUSH_NONE) && !l2_ans_vld_i && !mshr_full_i;

endmodule

// File: dtlb_port_pkg.sv
/*
 * Data TLB port types
 * LSQ and level-2 TLB bus structs, the stored entry, flush kinds
 * and the array scheduler choice
 */
`include "dtlb_consts.svh"

package dtlb_port_pkg;

  import dtlb_addr_pkg::*;

  // LSQ translation request
  typedef struct packed {
    logic                         valid;
    vpn_t                         vpn;
    logic                         is_store;
    logic [`DTLB_LSQ_ADDR_W-1:0]  lsq_addr;
  } lsq_req_t;

  // Same-cycle answer on a hit
  typedef struct packed {
    logic                         valid;
    ppn_t                         ppn;
    logic                         page_fault;
    logic                         was_store;
    logic [`DTLB_LSQ_ADDR_W-1:0]  lsq_addr;
  } lsq_ans_t;

  // Wake-up of LSQ slots waiting on a miss
  typedef struct packed {
    logic  valid;
    vpn_t  vpn;
    ppn_t  ppn;
    logic  page_fault;
  } lsq_wup_t;

  typedef struct packed {
    logic  valid;
    vpn_t  vpn;
  } l2_req_t;

  // Level-2 answer, PTE permission bits included
  typedef struct packed {
    logic   valid;
    vpn_t   vpn;
    ppn_t   ppn;
    page_e  page_type;
    logic   g_bit;
    logic   u_bit;
    logic   r_bit;
    logic   w_bit;
    logic   x_bit;
    logic   d_bit;
    logic   page_fault;
  } l2_ans_t;

  typedef struct packed {
    logic   valid;
    vpn_t   vpn;
    ppn_t   ppn;
    asid_t  asid;
    logic   glob;
    logic   user;
    logic   read;
    logic   write;
    logic   dirty;
    page_e  page_type;
  } tlb_entry_t;

  typedef enum logic [1:0] {
    FLUSH_NONE = 2'b00,
    FLUSH_ASID = 2'b01,
    FLUSH_ALL  = 2'b10
  } flush_e;

  typedef enum logic [1:0] {
    SCHED_IDLE    = 2'b00,
    SCHED_FLUSH   = 2'b01,
    SCHED_L2_ANS  = 2'b10,
    SCHED_LSQ_REQ = 2'b11
  } sched_e;

endpackage

// File: dtlb_addr_pkg.sv
/*
 * Data TLB address types
 * Virtual and physical page numbers, ASID, privilege, page size and indexes
 */
`include "dtlb_consts.svh"

package dtlb_addr_pkg;

  // One level of the Sv39 page walk
  typedef logic [`DTLB_VPN_LVL_W-1:0] vpn_lvl_t;
  // Level 2 is the top, level 0 the kibi offset level
  typedef vpn_lvl_t [2:0] vpn_t;
  typedef logic [`DTLB_PPN_W-1:0] ppn_t;
  typedef logic [`DTLB_ASID_W-1:0] asid_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01,
    PRIV_M = 2'b11
  } priv_e;

  typedef enum logic [1:0] {
    PAGE_KIBI = 2'b00,
    PAGE_MEBI = 2'b01,
    PAGE_GIBI = 2'b10
  } page_e;

  typedef logic [$clog2(`DTLB_ENTRIES)-1:0] tlb_idx_t;
  typedef logic [$clog2(`DTLB_MSHR_DEPTH)-1:0] mshr_idx_t;

endpackage

// File: dtlb_consts.svh
/*
 * Data TLB sizing constants
 * Entry count, miss table depth and the widths of the translation fields
 */
`ifndef DTLB_CONSTS_SVH
`define DTLB_CONSTS_SVH

// Entry count is a power of two for the round-robin pointer
`define DTLB_ENTRIES 8
// Outstanding level-2 misses
`define DTLB_MSHR_DEPTH 2

// Sv39 field widths
`define DTLB_VPN_LVL_W 9
`define DTLB_PPN_W 44
`define DTLB_ASID_W 16
// LSQ slot tag
`define DTLB_LSQ_ADDR_W 4

`endif
